// File: design/vga_consts.svh
// Video timing, framebuffer geometry and host register map
// Shared by the timing, memory, drawing and host blocks
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// 640x480 at 60 Hz from a 25 MHz pixel clock
`define VGA_H_DISPLAY 640   // Visible pixels per line
`define VGA_H_FRONT   16
`define VGA_H_SYNC    96    // hsync pulse width
`define VGA_H_BACK    48

`define VGA_V_DISPLAY 480   // Visible lines per frame
`define VGA_V_FRONT   10
`define VGA_V_SYNC    2     // vsync pulse, in lines
`define VGA_V_BACK    33

// Framebuffer in pixels, shown at 4x
`define FB_WIDTH       160
`define FB_HEIGHT      120
`define FB_SCALE_SHIFT 2    // log2 of screen pixels per fb pixel

// Host register offsets
`define REG_CMD    32'h0000_0000   // Write only, draw command
`define REG_STATUS 32'h0000_0004   // Read only, busy and frame count

`endif

// File: design/vga_pkg.sv
// Shared types: colour, draw command views, scan position, fb write
package vga_pkg;

    // 8-bit colour, RRRGGGBB
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb332_t;

    typedef enum logic [1:0] {
        NOP  = 2'd0,
        PLOT = 2'd1,
        FILL = 2'd2
    } draw_op_e;

    // Single pixel plot
    typedef struct packed {
        draw_op_e   op;        // Bits 31:30 in both views
        logic [7:0] x;
        logic [6:0] y;
        logic [6:0] reserved;
        rgb332_t    colour;
    } cmd_plot_t;

    // Whole-buffer fill
    typedef struct packed {
        draw_op_e    op;
        logic [21:0] reserved;
        rgb332_t     colour;
    } cmd_fill_t;

    // One command word, decoded by op
    typedef union packed {
        cmd_plot_t plot;
        cmd_fill_t fill;
    } draw_cmd_u;

    typedef struct packed {
        logic [9:0] h;         // Horizontal count
        logic [9:0] v;         // Vertical count
        logic       active;    // Inside visible area
    } scan_pos_t;

    typedef struct packed {
        logic [14:0] addr;     // y * width + x
        rgb332_t     colour;
        logic        en;
    } fb_write_t;

endpackage

// File: design/axil_cmd_slave.sv
// AXI4-Lite slave for the draw command and status registers
// Also counts frames on vsync falling edges
`timescale 1ns/10ps
`include "vga_consts.svh"

module axil_cmd_slave
    import vga_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // Write address and data
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    // Write response
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    // Read address and data
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Engine side
    input  logic        busy,
    input  logic        vsync,       // Video output vsync
    output logic        cmd_valid,
    output draw_cmd_u   cmd
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_accept;
    logic        wr_to_cmd;
    logic        rd_accept;
    logic [31:0] cmd_reg;        // Last command word
    logic [31:0] cmd_merged;     // Strobed bytes over old word
    logic        vsync_q;
    logic [15:0] frame_count;

    // Both channels together, only with engine idle and no B pending
    assign wr_accept = awvalid && wvalid && !busy && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign wr_to_cmd = (awaddr == `REG_CMD);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cmd_merged[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : cmd_reg[8*i +: 8];
        end
    end

    // Forward in the accept cycle
    assign cmd_valid = wr_accept && wr_to_cmd;
    assign cmd       = cmd_merged;

    assign arready   = !rvalid;   // One read outstanding at most
    assign rd_accept = arvalid && arready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            cmd_reg     <= '0;      // Decodes as NOP
            vsync_q     <= 1'b1;
            frame_count <= '0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;     // Held until taken
            end
            if (cmd_valid) begin
                cmd_reg <= cmd_merged;
            end

            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            vsync_q <= vsync;
            if (vsync_q && !vsync) begin
                frame_count <= frame_count + 16'd1;   // Wraps
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_to_cmd ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            if (araddr == `REG_STATUS) begin
                rdata <= {frame_count, 15'd0, busy};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;    // Unmapped
            end
        end
    end

endmodule

// File: design/draw_engine.sv
// Draw engine with single pixel plots and full-buffer fill sweeps
`timescale 1ns/10ps
`include "vga_consts.svh"

module draw_engine
    import vga_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  draw_cmd_u cmd,
    output logic      cmd_ready,
    output logic      busy,
    output fb_write_t fb_wr
);

    localparam int FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;

    logic        accept;
    logic        plot_in_range;
    logic [14:0] plot_addr;
    logic        plot_en;       // Plot write pending next cycle
    logic [14:0] plot_addr_q;
    rgb332_t     plot_colour_q;
    logic [14:0] fill_addr;
    rgb332_t     fill_colour;

    assign cmd_ready = !busy;
    assign accept    = cmd_valid && cmd_ready;

    // Plot view of the word
    assign plot_in_range = (cmd.plot.x < 8'(`FB_WIDTH)) && (cmd.plot.y < 7'(`FB_HEIGHT));
    assign plot_addr     = 15'(cmd.plot.y) * 15'(`FB_WIDTH) + 15'(cmd.plot.x);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            plot_en   <= 1'b0;
            fill_addr <= '0;
        end else begin
            plot_en <= 1'b0;
            if (accept) begin
                case (cmd.plot.op)            // Op sits in the same bits in both views
                    PLOT: plot_en <= plot_in_range;   // Off-screen is dropped
                    FILL: begin
                        busy      <= 1'b1;
                        fill_addr <= '0;
                    end
                    default: ;                // NOP and spare code
                endcase
            end else if (busy) begin
                fill_addr <= fill_addr + 15'd1;
                if (fill_addr == 15'(FB_PIXELS - 1)) begin
                    busy <= 1'b0;             // Last write this cycle
                end
            end
        end
    end

    // Operands taken from the view that matches the op
    always_ff @(posedge clk) begin
        if (accept && cmd.plot.op == PLOT) begin
            plot_addr_q   <= plot_addr;
            plot_colour_q <= cmd.plot.colour;
        end
        if (accept && cmd.fill.op == FILL) begin
            fill_colour <= cmd.fill.colour;   // Kept for the whole sweep
        end
    end

    // Fill owns the port while busy
    // Plot lands one cycle after accept
    always_comb begin
        if (busy) begin
            fb_wr.addr   = fill_addr;
            fb_wr.colour = fill_colour;
            fb_wr.en     = 1'b1;
        end else begin
            fb_wr.addr   = plot_addr_q;
            fb_wr.colour = plot_colour_q;
            fb_wr.en     = plot_en;
        end
    end

endmodule

// File: design/frame_buffer.sv
// Framebuffer: 160x120 of RGB332
// Write port for drawing, registered read port for scan-out
`timescale 1ns/10ps
`include "vga_consts.svh"

module frame_buffer
    import vga_pkg::*;
(
    input  logic        clk,
    input  fb_write_t   fb_wr,
    input  logic [14:0] rd_addr,
    output rgb332_t     rd_data
);

    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;

    rgb332_t mem [0:DEPTH-1];   // Undefined until drawn

    // Drawing side
    always_ff @(posedge clk) begin
        if (fb_wr.en) begin
            mem[fb_wr.addr] <= fb_wr.colour;
        end
    end

    // Scan-out side, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: design/vga_timing.sv
// VGA timing: h/v counters, registered syncs, pixel request, scan position
`timescale 1ns/10ps
`include "vga_consts.svh"

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_DISPLAY = `VGA_H_DISPLAY,
    parameter int H_FRONT   = `VGA_H_FRONT,
    parameter int H_SYNC    = `VGA_H_SYNC,
    parameter int H_BACK    = `VGA_H_BACK,
    parameter int V_DISPLAY = `VGA_V_DISPLAY,
    parameter int V_FRONT   = `VGA_V_FRONT,
    parameter int V_SYNC    = `VGA_V_SYNC,
    parameter int V_BACK    = `VGA_V_BACK
) (
    input  logic      clk,
    input  logic      rst_n,
    output logic      hsync,       // Active low
    output logic      vsync,       // Active low
    output logic      pixel_req,   // One cycle ahead of visible area
    output scan_pos_t pos
);

    localparam int H_TOTAL       = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int H_PULSE_START = H_DISPLAY + H_FRONT;
    localparam int H_PULSE_END   = H_PULSE_START + H_SYNC;
    localparam int V_TOTAL       = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam int V_PULSE_START = V_DISPLAY + V_FRONT;
    localparam int V_PULSE_END   = V_PULSE_START + V_SYNC;

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       h_end;         // Last cycle of a line
    logic       line_lead;     // Request before next visible line
    logic       frame_lead;    // Request before first line of frame

    assign h_end      = (h_count == 10'(H_TOTAL - 1));
    assign line_lead  = h_end && (v_count < 10'(V_DISPLAY - 1));
    assign frame_lead = h_end && (v_count == 10'(V_TOTAL - 1));

    // Leads visible pixels by one, drops on the last visible column
    assign pixel_req = ((h_count < 10'(H_DISPLAY - 1)) && (v_count < 10'(V_DISPLAY)))
                       || line_lead || frame_lead;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_count <= 10'(H_DISPLAY);   // Start in blanking
            v_count <= 10'(V_DISPLAY);
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            pos     <= '0;
        end else begin
            if (h_end) begin
                h_count <= '0;
                v_count <= (v_count == 10'(V_TOTAL - 1)) ? 10'd0 : v_count + 10'd1;
            end else begin
                h_count <= h_count + 10'd1;
            end

            hsync <= !((h_count >= 10'(H_PULSE_START)) && (h_count < 10'(H_PULSE_END)));
            vsync <= !((v_count >= 10'(V_PULSE_START)) && (v_count < 10'(V_PULSE_END)));

            // Same stage as the syncs
            pos.h      <= h_count;
            pos.v      <= v_count;
            pos.active <= (h_count < 10'(H_DISPLAY)) && (v_count < 10'(V_DISPLAY));
        end
    end

endmodule

// File: design/pixel_pipe.sv
// Pixel path: scan position to fb address, colour blanking, sync alignment
`timescale 1ns/10ps
`include "vga_consts.svh"

module pixel_pipe
    import vga_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  scan_pos_t   pos,
    input  logic        hsync,
    input  logic        vsync,
    output logic [14:0] rd_addr,
    input  rgb332_t     rd_data,     // One cycle after rd_addr
    output rgb332_t     rgb,
    output logic        de,
    output logic        hsync_out,
    output logic        vsync_out
);

    logic [9:0] fb_x;
    logic [9:0] fb_y;

    // 4x4 screen pixels per fb pixel
    assign fb_x = pos.h >> `FB_SCALE_SHIFT;
    assign fb_y = pos.v >> `FB_SCALE_SHIFT;

    // Parked at 0 in blanking, keeps the index in range
    assign rd_addr = pos.active ? 15'(fb_y) * 15'(`FB_WIDTH) + 15'(fb_x) : 15'd0;

    // Match the memory read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de        <= 1'b0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
        end else begin
            de        <= pos.active;
            hsync_out <= hsync;
            vsync_out <= vsync;
        end
    end

    assign rgb = de ? rd_data : '0;   // Black outside visible area

endmodule

// File: design/vga_display_top.sv
// VGA display top: AXI4-Lite host port, draw engine, framebuffer,
// timing generator and pixel path
`timescale 1ns/10ps
`include "vga_consts.svh"

module vga_display_top
    import vga_pkg::*;
#(
    parameter int H_DISPLAY = `VGA_H_DISPLAY,
    parameter int H_FRONT   = `VGA_H_FRONT,
    parameter int H_SYNC    = `VGA_H_SYNC,
    parameter int H_BACK    = `VGA_H_BACK,
    parameter int V_DISPLAY = `VGA_V_DISPLAY,
    parameter int V_FRONT   = `VGA_V_FRONT,
    parameter int V_SYNC    = `VGA_V_SYNC,
    parameter int V_BACK    = `VGA_V_BACK
) (
    input  logic        clk,         // 25 MHz, host and pixels
    input  logic        rst_n,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output rgb332_t     rgb,
    output logic        de,
    output logic        hsync,
    output logic        vsync
);

    logic        cmd_valid;
    draw_cmd_u   cmd;
    logic        busy;
    fb_write_t   fb_wr;
    logic [14:0] rd_addr;
    rgb332_t     rd_data;
    logic        tim_hsync;     // Timing stage syncs, before alignment
    logic        tim_vsync;
    scan_pos_t   pos;

    axil_cmd_slave i_axil_cmd_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .busy      (busy),
        .vsync     (vsync),          // Counts frames as shown
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    // Slave gates on busy, the same condition as cmd_ready
    draw_engine i_draw_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (),
        .busy      (busy),
        .fb_wr     (fb_wr)
    );

    frame_buffer i_frame_buffer (
        .clk     (clk),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Pixel path fetches from pos, so the request lead is not needed
    vga_timing #(
        .H_DISPLAY (H_DISPLAY),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_DISPLAY (V_DISPLAY),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_vga_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsync     (tim_hsync),
        .vsync     (tim_vsync),
        .pixel_req (),
        .pos       (pos)
    );

    pixel_pipe i_pixel_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .pos       (pos),
        .hsync     (tim_hsync),
        .vsync     (tim_vsync),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rgb       (rgb),
        .de        (de),
        .hsync_out (hsync),
        .vsync_out (vsync)
    );

endmodule

// File: bench/tb_vga_display.sv
// Testbench for the VGA display subsystem in a tiny video mode
// AXI4-Lite host tasks, framebuffer model, concurrent checks, timeout
`timescale 1ns/10ps
`include "vga_consts.svh"

module tb_vga_display
    import vga_pkg::*;
();

    // Tiny mode with 48 cycles per line and 22 lines per frame
    localparam int H_DISPLAY    = 32;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 4;
    localparam int V_DISPLAY    = 16;
    localparam int V_FRONT      = 2;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam int FB_PIXELS    = `FB_WIDTH * `FB_HEIGHT;
    localparam int VIS_FB_W     = H_DISPLAY >> `FB_SCALE_SHIFT;   // Visible fb columns
    localparam int VIS_FB_H     = V_DISPLAY >> `FB_SCALE_SHIFT;
    localparam int MAX_CYCLES   = 60000;    // Covers two fills plus ten frames
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        clk;
    logic        rst_n;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    rgb332_t     rgb;
    logic        de;
    logic        hsync;
    logic        vsync;

    logic [7:0]  model [0:FB_PIXELS-1];     // Reference framebuffer
    logic [7:0]  expect_rgb;
    integer      seed = 32'h5936_b16c;
    int          error_count = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          cycle_count = 0;

    // Monitor state counted from DUT outputs
    logic        hs_prev;
    logic        vs_prev;
    logic        de_prev;
    logic        busy_prev;
    logic        hs_seen;          // First hsync fall seen
    logic        frame_seen;       // First vsync fall seen
    logic        check_pixels;     // Pixel compare window
    int          hs_low_len;
    int          hs_period;
    int          vs_low_len;
    int          vs_period;
    int          x_pos;            // de cycles so far in this line
    int          line_idx;         // de lines since vsync fall
    int          vsync_falls;
    int          checked_pixels;
    int          busy_len;

    wire eng_busy = i_vga_display_top.busy;   // Internal engine state
    wire hs_fall  = !hsync && hs_prev;
    wire hs_rise  = hsync && !hs_prev;
    wire vs_fall  = !vsync && vs_prev;
    wire vs_rise  = vsync && !vs_prev;
    wire de_fall  = !de && de_prev;
    wire busy_end = !eng_busy && busy_prev;

    vga_display_top #(
        .H_DISPLAY (H_DISPLAY),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_DISPLAY (V_DISPLAY),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_vga_display_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rgb     (rgb),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Screen pixel to model entry at 4x4 per fb pixel
    assign expect_rgb = model[(line_idx >> `FB_SCALE_SHIFT) * `FB_WIDTH
                              + (x_pos >> `FB_SCALE_SHIFT)];

    always @(posedge clk) begin
        if (!rst_n) begin
            hs_prev        <= 1'b1;
            vs_prev        <= 1'b1;
            de_prev        <= 1'b0;
            busy_prev      <= 1'b0;
            hs_seen        <= 1'b0;
            frame_seen     <= 1'b0;
            hs_low_len     <= 0;
            hs_period      <= 0;
            vs_low_len     <= 0;
            vs_period      <= 0;
            x_pos          <= 0;
            line_idx       <= 0;
            vsync_falls    <= 0;
            checked_pixels <= 0;
            busy_len       <= 0;
        end else begin
            hs_prev    <= hsync;
            vs_prev    <= vsync;
            de_prev    <= de;
            busy_prev  <= eng_busy;
            hs_low_len <= hsync ? 0 : hs_low_len + 1;
            hs_period  <= hs_fall ? 1 : hs_period + 1;
            vs_low_len <= vsync ? 0 : vs_low_len + 1;
            vs_period  <= vs_fall ? 1 : vs_period + 1;
            x_pos      <= de ? x_pos + 1 : 0;
            busy_len   <= eng_busy ? busy_len + 1 : 0;
            if (hs_fall) begin
                hs_seen <= 1'b1;
            end
            if (vs_fall) begin
                frame_seen  <= 1'b1;
                vsync_falls <= vsync_falls + 1;
                line_idx    <= 0;                  // New frame
            end else if (de_fall) begin
                line_idx <= line_idx + 1;
            end
            if (check_pixels && de) begin
                checked_pixels <= checked_pixels + 1;
            end else if (!check_pixels) begin
                checked_pixels <= 0;
            end
        end
    end

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // Sync widths and periods
    a_hs_width: assert property (@(posedge clk) disable iff (!rst_n)
        hs_rise |-> (hs_low_len == H_SYNC))
        else report_error($sformatf("hsync low for %0d cycles", $sampled(hs_low_len)));
    a_hs_period: assert property (@(posedge clk) disable iff (!rst_n)
        (hs_fall && hs_seen) |-> (hs_period == H_TOTAL))
        else report_error($sformatf("hsync period %0d cycles", $sampled(hs_period)));
    a_vs_width: assert property (@(posedge clk) disable iff (!rst_n)
        vs_rise |-> (vs_low_len == V_SYNC * H_TOTAL))
        else report_error($sformatf("vsync low for %0d cycles", $sampled(vs_low_len)));
    a_vs_period: assert property (@(posedge clk) disable iff (!rst_n)
        (vs_fall && frame_seen) |-> (vs_period == V_TOTAL * H_TOTAL))
        else report_error($sformatf("vsync period %0d cycles", $sampled(vs_period)));

    // Visible area
    a_line_width: assert property (@(posedge clk) disable iff (!rst_n)
        de_fall |-> (x_pos == H_DISPLAY))
        else report_error($sformatf("%0d de cycles in a line", $sampled(x_pos)));
    a_frame_lines: assert property (@(posedge clk) disable iff (!rst_n)
        (vs_fall && frame_seen) |-> (line_idx == V_DISPLAY))
        else report_error($sformatf("%0d de lines in a frame", $sampled(line_idx)));
    a_de_in_sync: assert property (@(posedge clk) disable iff (!rst_n)
        !(de && (!hsync || !vsync)))
        else report_error("de high while a sync pulse is active");
    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        !de |-> (rgb == 8'h00))
        else report_error($sformatf("rgb %h outside visible area", $sampled(rgb)));
    a_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        (check_pixels && de) |-> (rgb == expect_rgb))
        else report_error($sformatf("pixel (%0d,%0d) is %h, expected %h", $sampled(x_pos),
                          $sampled(line_idx), $sampled(rgb), $sampled(expect_rgb)));

    // Fill length and host back-pressure
    a_fill_len: assert property (@(posedge clk) disable iff (!rst_n)
        busy_end |-> (busy_len == FB_PIXELS))
        else report_error($sformatf("busy lasted %0d cycles", $sampled(busy_len)));
    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        eng_busy |-> !awready)
        else report_error("awready high while the engine is busy");

    // Ends a hung run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] make_fill(input logic [7:0] colour);
        return {FILL, 22'd0, colour};
    endfunction

    function automatic logic [31:0] make_plot(input int x, input int y,
                                              input logic [7:0] colour);
        return {PLOT, 8'(x), 7'(y), 7'd0, colour};
    endfunction

    // Drives both channels together and waits for B
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp, output int waited);
        waited  = 0;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
    endtask

    // Also returns the vsync falls counted at address acceptance
    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, output int falls);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        falls   = vsync_falls;
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
    endtask

    task automatic wait_idle();
        logic [31:0] data;
        logic [1:0]  resp;
        int          falls;
        do begin
            axi_read(`REG_STATUS, data, resp, falls);
        end while (data[0]);
    endtask

    task automatic wait_frames(input int n);
        int start;
        start = vsync_falls;
        while (vsync_falls < start + n) @(posedge clk);
    endtask

    // One whole visible area between two vsync falls
    task automatic check_frame();
        int start;
        start = vsync_falls;
        while (vsync_falls == start) @(posedge clk);
        check_pixels <= 1'b1;
        start = vsync_falls;
        while (vsync_falls == start) @(posedge clk);
        check_pixels <= 1'b0;
        assert (checked_pixels == H_DISPLAY * V_DISPLAY)
            else report_error($sformatf("only %0d pixels compared", checked_pixels));
    endtask

    task automatic model_fill(input logic [7:0] colour);
        for (int i = 0; i < FB_PIXELS; i++) begin
            model[i] = colour;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_ok++;
            $display("[%0t ns] %s: ok", $time, name);
        end else begin
            tests_bad++;
            $display("[%0t ns] %s: FAILED, %0d errors", $time, name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        int          errors_before;
        int          waited;
        int          px;
        int          py;
        int          falls_a;
        int          falls_b;
        logic [7:0]  colour;
        logic [1:0]  resp;
        logic [31:0] data;
        logic [31:0] status_a;

        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b1;     // Responses always taken
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        check_pixels = 1'b0;
        rst_n        = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values and free-running syncs
        errors_before = error_count;
        assert (hsync && vsync && !de && rgb == 8'h00 && !bvalid && !rvalid && !eng_busy)
            else report_error("outputs not at reset values");
        wait_frames(3);
        finish_test("sync and visible area", errors_before);

        errors_before = error_count;
        colour = 8'($random(seed));
        axi_write(`REG_CMD, make_fill(colour), resp, waited);
        assert (resp == RESP_OKAY) else report_error("fill write not OKAY");
        model_fill(colour);
        wait_idle();
        check_frame();
        finish_test("fill", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            px     = $unsigned($random(seed)) % VIS_FB_W;   // Visible part only
            py     = $unsigned($random(seed)) % VIS_FB_H;
            colour = 8'($random(seed));
            axi_write(`REG_CMD, make_plot(px, py, colour), resp, waited);
            assert (resp == RESP_OKAY) else report_error("plot write not OKAY");
            model[py * `FB_WIDTH + px] = colour;
        end
        check_frame();
        finish_test("plot", errors_before);

        errors_before = error_count;
        colour = 8'($random(seed));
        axi_write(`REG_CMD, make_fill(colour), resp, waited);
        model_fill(colour);
        colour = ~colour;
        axi_write(`REG_CMD, make_plot(0, 0, colour), resp, waited);   // Held off by fill
        assert (waited >= FB_PIXELS - 2)
            else report_error($sformatf("second command taken after %0d cycles", waited));
        assert (resp == RESP_OKAY) else report_error("plot after fill not OKAY");
        model[0] = colour;
        axi_write(32'h8, make_plot(0, 0, ~colour), resp, waited);     // Must not draw
        assert (resp == RESP_SLVERR) else report_error("write to 0x8 not SLVERR");
        axi_read(32'hC, data, resp, falls_a);
        assert (resp == RESP_SLVERR && data == 32'd0)
            else report_error($sformatf("read of 0xC gave %h, resp %b", data, resp));
        axi_read(`REG_STATUS, status_a, resp, falls_a);
        check_frame();
        axi_read(`REG_STATUS, data, resp, falls_b);
        assert (resp == RESP_OKAY
                && data[31:16] - status_a[31:16] == 16'(falls_b - falls_a))
            else report_error($sformatf("frame count moved by %0d, vsync fell %0d times",
                              data[31:16] - status_a[31:16], falls_b - falls_a));
        finish_test("host port", errors_before);

        $display("Summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, error_count);
        if (tests_bad == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/vga_pkg.sv
design/axil_cmd_slave.sv
design/draw_engine.sv
design/frame_buffer.sv
design/vga_timing.sv
design/pixel_pipe.sv
design/vga_display_top.sv
bench/tb_vga_display.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_vga_display
FILELIST = vlog.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

# Output is searched for the pass message, the status follows grep
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)
